//--- rtl/sram_settings.svh
//////////////////////////////
// SRAM subsystem settings
// Bus widths, chip widths and request queue depth
//////////////////////////////

`ifndef SRAM_SETTINGS_SVH
`define SRAM_SETTINGS_SVH

`define SRAM_BUS_DATA_WIDTH  32
`define SRAM_BUS_ADDR_WIDTH  32
`define SRAM_DATA_WIDTH      16
`define SRAM_ADDR_WIDTH      20
// Must be a power of two
`define SRAM_REQ_QUEUE_DEPTH 4

`endif

//--- rtl/sram_pkg.sv
//////////////////////////////
// SRAM subsystem types
// Bus request/response structs and controller states
//////////////////////////////

`default_nettype none

`include "sram_settings.svh"

package sram_pkg;

    typedef logic [`SRAM_BUS_DATA_WIDTH-1:0]   bus_data_t;
    typedef logic [`SRAM_BUS_ADDR_WIDTH-1:0]   bus_addr_t;
    typedef logic [`SRAM_BUS_DATA_WIDTH/8-1:0] bus_sel_t;
    typedef logic [`SRAM_DATA_WIDTH-1:0]       sram_data_t;
    typedef logic [`SRAM_ADDR_WIDTH-1:0]       sram_addr_t;

    typedef struct packed {
        logic      we;
        bus_sel_t  sel;
        bus_addr_t addr;
        bus_data_t wdata;
    } sram_req_t;

    typedef struct packed {
        logic      we;
        bus_data_t rdata;
    } sram_rsp_t;

    typedef enum logic [2:0] {
        IDLE         = 3'd0,
        READ_GATHER  = 3'd1,
        WRITE_GATHER = 3'd2,
        UNALIGNED    = 3'd3,
        ACK          = 3'd4
    } sram_ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/sram_req_queue.sv
//////////////////////////////
// SRAM request queue
// Buffers bus requests ahead of the SRAM controller
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "sram_settings.svh"

module sram_req_queue
    import sram_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst_n,

    input  logic      i_push_valid,
    input  sram_req_t i_push_req,
    output logic      o_push_ready,

    output logic      o_pop_valid,
    output sram_req_t o_pop_req,
    input  logic      i_pop_ready
);

    localparam int DEPTH  = `SRAM_REQ_QUEUE_DEPTH;
    localparam int IDX_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    sram_req_t mem [DEPTH];

    // Pointers carry one extra wrap bit above the entry index
    logic [IDX_W:0] wr_ptr_r;
    logic [IDX_W:0] rd_ptr_r;

    logic full;
    logic empty;
    logic push;
    logic pop;

    assign empty = (wr_ptr_r == rd_ptr_r);
    assign full  = (wr_ptr_r[IDX_W] != rd_ptr_r[IDX_W]) &&
                   (wr_ptr_r[IDX_W-1:0] == rd_ptr_r[IDX_W-1:0]);

    assign push = i_push_valid && !full;
    assign pop  = i_pop_ready && !empty;

    assign o_push_ready = !full;
    assign o_pop_valid  = !empty;
    assign o_pop_req    = mem[rd_ptr_r[IDX_W-1:0]];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
        end else begin
            if (push) wr_ptr_r <= wr_ptr_r + 1'b1;
            if (pop)  rd_ptr_r <= rd_ptr_r + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr_r[IDX_W-1:0]] <= i_push_req;
    end

    // Head entry must not move while it waits for the controller
    a_pop_stable : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        (o_pop_valid && !i_pop_ready) |=> (o_pop_valid && $stable(o_pop_req))
    );

endmodule

`default_nettype wire

//--- rtl/sram_ctrl.sv
//////////////////////////////
// SRAM controller
// Splits 32-bit requests into 16-bit async SRAM cycles
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "sram_settings.svh"

module sram_ctrl
    import sram_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,

    // Request side
    input  logic       i_req_valid,
    input  sram_req_t  i_req,
    output logic       o_req_ready,

    // Response side
    output logic       o_rsp_valid,
    output sram_rsp_t  o_rsp,
    input  logic       i_rsp_ready,

    // SRAM pins
    output logic       o_sram_ce_n,
    output logic       o_sram_oe_n,
    output logic       o_sram_we_n,
    output logic       o_sram_lb_n,
    output logic       o_sram_ub_n,
    output sram_addr_t o_sram_addr,
    output sram_data_t o_sram_dq,
    output logic       o_sram_dq_oe,
    input  sram_data_t i_sram_dq
);

    localparam int BUS_W   = `SRAM_BUS_DATA_WIDTH;
    localparam int LANE_W  = `SRAM_DATA_WIDTH;
    localparam int LANES   = LANE_W / 8;
    // Room for one extra SRAM word when the access starts on an odd byte
    localparam int IMG_W   = BUS_W + LANE_W;
    localparam int SEL_W   = IMG_W / 8;

    sram_ctrl_state_t state_r;
    sram_ctrl_state_t state_next;

    logic [1:0] idx_r;
    logic [1:0] idx_next;

    sram_req_t        req_r;
    logic [IMG_W-1:0] wr_img_r;
    logic [SEL_W-1:0] sel_img_r;
    logic [IMG_W-1:0] rd_img_r;

    logic             accept;
    logic             access;
    logic             wr_cyc;
    logic             odd;
    logic             in_odd;
    logic [IMG_W-1:0] in_img;
    logic [SEL_W-1:0] in_sel;
    logic [LANES-1:0] lane_sel;
    sram_rsp_t        rsp_c;

    assign accept = (state_r == IDLE) && i_req_valid;
    assign access = (state_r == READ_GATHER) || (state_r == WRITE_GATHER) ||
                    (state_r == UNALIGNED);
    assign wr_cyc = (state_r == WRITE_GATHER) || ((state_r == UNALIGNED) && req_r.we);
    assign odd    = req_r.addr[0];

    // Shift data and selects up one byte for odd addresses
    assign in_odd = i_req.addr[0];
    assign in_img = in_odd ? {8'b0, i_req.wdata, 8'b0} : {{LANE_W{1'b0}}, i_req.wdata};
    assign in_sel = in_odd ? {1'b0, i_req.sel, 1'b0} : {{LANES{1'b0}}, i_req.sel};

    always_comb begin
        state_next = state_r;
        idx_next   = idx_r;
        case (state_r)
            IDLE: begin
                idx_next = '0;
                if (i_req_valid) begin
                    state_next = i_req.we ? WRITE_GATHER : READ_GATHER;
                end
            end
            READ_GATHER, WRITE_GATHER: begin
                idx_next = idx_r + 1'b1;
                if (idx_r == 2'd1) begin
                    state_next = odd ? UNALIGNED : ACK;
                end
            end
            UNALIGNED: begin
                state_next = ACK;
            end
            ACK: begin
                if (i_rsp_ready) state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
                idx_next   = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= IDLE;
            idx_r   <= '0;
        end else begin
            state_r <= state_next;
            idx_r   <= idx_next;
        end
    end

    // The chip answers within the cycle, so each half is taken at the closing edge
    always_ff @(posedge clk) begin
        if (accept) begin
            req_r     <= i_req;
            wr_img_r  <= in_img;
            sel_img_r <= in_sel;
        end
        if (access) begin
            rd_img_r[idx_r*LANE_W +: LANE_W] <= i_sram_dq;
        end
    end

    assign lane_sel = sel_img_r[idx_r*LANES +: LANES];

    assign rsp_c.we    = req_r.we;
    assign rsp_c.rdata = req_r.we ? '0 :
                         (odd ? rd_img_r[BUS_W+7:8] : rd_img_r[BUS_W-1:0]);

    assign o_req_ready = (state_r == IDLE);
    assign o_rsp_valid = (state_r == ACK);
    assign o_rsp       = rsp_c;

    // Chip and output enable stay asserted while the write strobe overrides the output
    assign o_sram_ce_n  = 1'b0;
    assign o_sram_oe_n  = 1'b0;
    assign o_sram_we_n  = !wr_cyc;
    assign o_sram_lb_n  = !(access && lane_sel[0]);
    assign o_sram_ub_n  = !(access && lane_sel[1]);
    assign o_sram_addr  = req_r.addr[`SRAM_ADDR_WIDTH:1] + sram_addr_t'(idx_r);
    assign o_sram_dq    = wr_img_r[idx_r*LANE_W +: LANE_W];
    assign o_sram_dq_oe = wr_cyc;

    a_rsp_stable : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        (state_r == ACK && !i_rsp_ready) |=> (o_rsp_valid && $stable(o_rsp))
    );

    // Write strobe stays inside the words of a latched write, the third only when odd
    a_we_in_write : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        !o_sram_we_n |-> (access && req_r.we && (idx_r != 2'd2 || odd))
    );

endmodule

`default_nettype wire

//--- rtl/sram_subsys_top.sv
//////////////////////////////
// SRAM subsystem top
// Request queue feeding the SRAM controller
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "sram_settings.svh"

module sram_subsys_top
    import sram_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,

    // Bus request port
    input  logic       i_req_valid,
    input  sram_req_t  i_req,
    output logic       o_req_ready,

    // Bus response port
    output logic       o_rsp_valid,
    output sram_rsp_t  o_rsp,
    input  logic       i_rsp_ready,

    // SRAM pins, data bus split for an external pad
    output logic       o_sram_ce_n,
    output logic       o_sram_oe_n,
    output logic       o_sram_we_n,
    output logic       o_sram_lb_n,
    output logic       o_sram_ub_n,
    output sram_addr_t o_sram_addr,
    output sram_data_t o_sram_dq,
    output logic       o_sram_dq_oe,
    input  sram_data_t i_sram_dq
);

    logic      q_valid;
    logic      q_ready;
    sram_req_t q_req;

    sram_req_queue sram_req_queue_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_push_valid (i_req_valid),
        .i_push_req   (i_req),
        .o_push_ready (o_req_ready),
        .o_pop_valid  (q_valid),
        .o_pop_req    (q_req),
        .i_pop_ready  (q_ready)
    );

    sram_ctrl sram_ctrl_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_req_valid  (q_valid),
        .i_req        (q_req),
        .o_req_ready  (q_ready),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp        (o_rsp),
        .i_rsp_ready  (i_rsp_ready),
        .o_sram_ce_n  (o_sram_ce_n),
        .o_sram_oe_n  (o_sram_oe_n),
        .o_sram_we_n  (o_sram_we_n),
        .o_sram_lb_n  (o_sram_lb_n),
        .o_sram_ub_n  (o_sram_ub_n),
        .o_sram_addr  (o_sram_addr),
        .o_sram_dq    (o_sram_dq),
        .o_sram_dq_oe (o_sram_dq_oe),
        .i_sram_dq    (i_sram_dq)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
//////////////////////////////
// Testbench clock, 4 ns period
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic o_clk
);

    initial o_clk = 1'b0;

    always #2 o_clk = ~o_clk;

endmodule

`default_nettype wire

//--- sim/sram_chip_model.sv
//////////////////////////////
// Async 16-bit SRAM chip model
// Byte lanes with a preset fill
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "sram_settings.svh"

module sram_chip_model (
    input  logic                          i_clk,
    input  logic                          i_ce_n,
    input  logic                          i_oe_n,
    input  logic                          i_we_n,
    input  logic                          i_lb_n,
    input  logic                          i_ub_n,
    input  logic [`SRAM_ADDR_WIDTH-1:0]   i_addr,
    input  logic [`SRAM_DATA_WIDTH-1:0]   i_dq,
    output logic [`SRAM_DATA_WIDTH-1:0]   o_dq
);

    localparam int WORDS = 1 << `SRAM_ADDR_WIDTH;

    logic [7:0] mem_lo [WORDS];
    logic [7:0] mem_hi [WORDS];

    // Preset byte value, mixes every bit of the byte address
    function automatic logic [7:0] fill_byte(input logic [`SRAM_ADDR_WIDTH:0] a);
        return a[7:0] ^ a[15:8] ^ {3'b0, a[20:16]} ^ 8'h5a;
    endfunction

    initial begin
        for (int w = 0; w < WORDS; w++) begin
            mem_lo[w] = fill_byte({w[`SRAM_ADDR_WIDTH-1:0], 1'b0});
            mem_hi[w] = fill_byte({w[`SRAM_ADDR_WIDTH-1:0], 1'b1});
        end
    end

    // The write strobe ends at the clock edge, so the lanes are stored there
    always @(posedge i_clk) begin
        if (!i_ce_n && !i_we_n) begin
            if (!i_lb_n) mem_lo[i_addr] = i_dq[7:0];
            if (!i_ub_n) mem_hi[i_addr] = i_dq[15:8];
        end
    end

    // Read path is purely combinational, disabled lanes read as zero
    assign o_dq = (!i_ce_n && !i_oe_n && i_we_n) ?
                  {i_ub_n ? 8'h00 : mem_hi[i_addr], i_lb_n ? 8'h00 : mem_lo[i_addr]} : '0;

endmodule

`default_nettype wire

//--- sim/tb_sram_subsys.sv
//////////////////////////////
// SRAM subsystem testbench
// Random traffic checked against a byte model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "sram_settings.svh"

module tb_sram_subsys
    import sram_pkg::*;
();

    localparam int TIMEOUT = 1000;
    localparam int DEPTH   = `SRAM_REQ_QUEUE_DEPTH;

    typedef logic [`SRAM_ADDR_WIDTH:0] byte_addr_t;

    logic       clk;
    logic       i_rst_n;
    logic       i_req_valid;
    sram_req_t  i_req;
    logic       o_req_ready;
    logic       o_rsp_valid;
    sram_rsp_t  o_rsp;
    logic       i_rsp_ready;
    logic       o_sram_ce_n;
    logic       o_sram_oe_n;
    logic       o_sram_we_n;
    logic       o_sram_lb_n;
    logic       o_sram_ub_n;
    sram_addr_t o_sram_addr;
    sram_data_t o_sram_dq;
    logic       o_sram_dq_oe;
    sram_data_t i_sram_dq;
    sram_data_t chip_dq;

    integer     seed     = 66;
    int         errors   = 0;
    int         bp_mode  = 0;
    logic       saw_full = 1'b0;

    logic [7:0] model_mem [byte_addr_t];
    sram_rsp_t  exp_q [$];
    bus_data_t  mask_q [$];

    tb_clock_gen clock_gen_i (.o_clk(clk));

    sram_subsys_top sram_subsys_top_i (.*);

    // Pad on the board, the controller owns the data bus while it writes
    assign i_sram_dq = o_sram_dq_oe ? o_sram_dq : chip_dq;

    sram_chip_model chip_i (
        .i_clk  (clk),
        .i_ce_n (o_sram_ce_n),
        .i_oe_n (o_sram_oe_n),
        .i_we_n (o_sram_we_n),
        .i_lb_n (o_sram_lb_n),
        .i_ub_n (o_sram_ub_n),
        .i_addr (o_sram_addr),
        .i_dq   (i_sram_dq),
        .o_dq   (chip_dq)
    );

    function automatic logic [7:0] fill_byte(input byte_addr_t a);
        return a[7:0] ^ a[15:8] ^ {3'b0, a[20:16]} ^ 8'h5a;
    endfunction

    function automatic logic [7:0] model_byte(input byte_addr_t a);
        if (model_mem.exists(a))
            return model_mem[a];
        return fill_byte(a);
    endfunction

    task automatic log_mismatch(input string sig, input logic [63:0] exp, input logic [63:0] got);
        $display("error at %0t: %s expected %h got %h", $time, sig, exp, got);
        errors++;
    endtask

    task automatic end_run();
        $display("Errors: %0d, responses outstanding: %0d", errors, exp_q.size());
        if (errors == 0 && exp_q.size() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // Bus byte k lives at byte address addr+k, wrapping at the chip size
    task automatic send(input sram_req_t r);
        sram_rsp_t  exp;
        bus_data_t  mask;
        byte_addr_t ba;
        int         n;
        exp    = '0;
        exp.we = r.we;
        mask   = r.we ? '1 : '0;
        for (int k = 0; k < 4; k++) begin
            ba = r.addr[`SRAM_ADDR_WIDTH:0] + byte_addr_t'(k);
            if (r.we && r.sel[k])
                model_mem[ba] = r.wdata[8*k +: 8];
            if (!r.we && r.sel[k]) begin
                exp.rdata[8*k +: 8] = model_byte(ba);
                mask[8*k +: 8] = 8'hff;
            end
        end
        @(negedge clk);
        i_req_valid = 1'b1;
        i_req = r;
        n = 0;
        while (!o_req_ready) begin
            saw_full = 1'b1;
            if (exp_q.size() < DEPTH)
                log_mismatch("o_req_ready", 64'd1, 64'(o_req_ready));
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("Timeout at %0t: the request port never became ready", $time);
                errors++;
                end_run();
            end
        end
        exp_q.push_back(exp);
        mask_q.push_back(mask);
    endtask

    task automatic send_random(input byte_addr_t base, input int span);
        sram_req_t   r;
        logic [31:0] rnd;
        rnd     = $random(seed);
        r.we    = rnd[31];
        r.sel   = rnd[27:24];
        r.addr  = $random(seed);
        r.wdata = $random(seed);
        r.addr[`SRAM_ADDR_WIDTH:0] = base + byte_addr_t'(rnd[15:0] % span);
        send(r);
    endtask

    task automatic drain();
        int n;
        n = 0;
        @(negedge clk);
        i_req_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("Timeout at %0t: %0d responses never arrived", $time, exp_q.size());
                errors++;
                end_run();
            end
        end
    endtask

    // Response side, drives back-pressure and checks each accepted response
    initial begin : rsp_monitor
        int          stall;
        logic        holding;
        logic [31:0] rnd;
        sram_rsp_t   held;
        sram_rsp_t   exp;
        bus_data_t   mask;
        stall   = 0;
        holding = 1'b0;
        forever begin
            @(negedge clk);
            rnd = $random(seed);
            if (stall > 0) begin
                stall--;
                i_rsp_ready = 1'b0;
            end else if (bp_mode == 2 && rnd[3:0] == 4'd0) begin
                stall = 4 + int'(rnd[8:4]);
                i_rsp_ready = 1'b0;
            end else if (bp_mode == 1) begin
                i_rsp_ready = rnd[0];
            end else begin
                i_rsp_ready = 1'b1;
            end
            if (holding && !o_rsp_valid) begin
                $display("Response at %0t was withdrawn before it was accepted", $time);
                errors++;
            end else if (holding && o_rsp !== held) begin
                log_mismatch("o_rsp", 64'(held), 64'(o_rsp));
            end
            holding = o_rsp_valid && !i_rsp_ready;
            held    = o_rsp;
            if (o_rsp_valid && i_rsp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Response at %0t arrived with no request outstanding", $time);
                    errors++;
                end else begin
                    exp  = exp_q.pop_front();
                    mask = mask_q.pop_front();
                    if (o_rsp.we !== exp.we)
                        log_mismatch("o_rsp.we", 64'(exp.we), 64'(o_rsp.we));
                    if ((o_rsp.rdata & mask) !== exp.rdata)
                        log_mismatch("o_rsp.rdata", 64'(exp.rdata), 64'(o_rsp.rdata & mask));
                end
            end
        end
    end

    initial begin
        bus_addr_t   a;
        logic [31:0] rnd;
        i_rst_n     = 1'b0;
        i_req_valid = 1'b0;
        i_req       = '0;
        i_rsp_ready = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        @(negedge clk);
        if (o_rsp_valid !== 1'b0)
            log_mismatch("o_rsp_valid", 64'd0, 64'(o_rsp_valid));
        if (o_req_ready !== 1'b1)
            log_mismatch("o_req_ready", 64'd1, 64'(o_req_ready));
        if ({o_sram_we_n, o_sram_lb_n, o_sram_ub_n} !== 3'b111)
            log_mismatch("o_sram_we_n/lb_n/ub_n", 64'd7, 64'({o_sram_we_n, o_sram_lb_n, o_sram_ub_n}));
        if (o_sram_dq_oe !== 1'b0)
            log_mismatch("o_sram_dq_oe", 64'd0, 64'(o_sram_dq_oe));

        // Aligned full word, then read back
        send(sram_req_t'{we: 1'b1, sel: 4'hf, addr: 32'h100, wdata: 32'hcafe_f00d});
        send(sram_req_t'{we: 1'b0, sel: 4'hf, addr: 32'h100, wdata: '0});
        drain();

        // Partial writes leave the fill bytes in the other lanes
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            a = 32'h200 + 32'(4 * i);
            send(sram_req_t'{we: 1'b1, sel: rnd[3:0], addr: a, wdata: $random(seed)});
            send(sram_req_t'{we: 1'b0, sel: 4'hf, addr: a, wdata: '0});
        end
        drain();

        // Odd addresses, plus the aligned words they overlap
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            a = 32'h301 + 32'(8 * i) + {29'b0, rnd[5:4], 1'b0};
            send(sram_req_t'{we: 1'b1, sel: rnd[3:0], addr: a, wdata: $random(seed)});
            send(sram_req_t'{we: 1'b0, sel: 4'hf, addr: a, wdata: '0});
            send(sram_req_t'{we: 1'b0, sel: 4'hf, addr: a & ~32'h3, wdata: '0});
            send(sram_req_t'{we: 1'b0, sel: 4'hf, addr: (a & ~32'h3) + 32'h4, wdata: '0});
        end
        send(sram_req_t'{we: 1'b1, sel: 4'hf, addr: 32'h001f_ffff, wdata: 32'h1234_5678});
        send(sram_req_t'{we: 1'b0, sel: 4'hf, addr: 32'h001f_ffff, wdata: '0});
        drain();

        // Long response stalls must back up into the queue
        bp_mode  = 2;
        saw_full = 1'b0;
        repeat (24) send_random(21'h400, 64);
        drain();
        if (!saw_full) begin
            $display("The request port never stalled while responses were held back");
            errors++;
        end

        // Mixed traffic in a small window so accesses collide
        bp_mode = 1;
        repeat (300) send_random(21'h500, 48);
        drain();
        end_run();
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+rtl
rtl/sram_pkg.sv
rtl/sram_req_queue.sv
rtl/sram_ctrl.sv
rtl/sram_subsys_top.sv
sim/tb_clock_gen.sv
sim/sram_chip_model.sv
sim/tb_sram_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the SRAM subsystem testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary -j 0 --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_sram_subsys -f verilog.f > build.log 2>&1 \
    || { cat build.log; echo "Build error, see build.log"; exit 1; }
./obj_dir/Vtb_sram_subsys > "$LOG" 2>&1
cat "$LOG"
grep -q "Simulation failed" "$LOG" && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" "$LOG" && { echo "PASS"; exit 0; }
echo "FAIL: the run ended without a result line"
exit 1
